/* src/alu_macros.svh */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// datapath and bus widths
`define ALU_DW      8
`define AXIL_AW     8
`define AXIL_DW     32

// register map, byte offsets
`define REG_A_OFS   8'h00
`define REG_X_OFS   8'h04
`define REG_Y_OFS   8'h08
`define CMD_OFS     8'h0C
`define STATUS_OFS  8'h10
`define FLAGCTL_OFS 8'h14

`endif

/* src/alu_pkg.sv */
`default_nettype none

`include "alu_macros.svh"

package alu_pkg;

   typedef enum logic [3:0] {
      op_pass = 4'd0,
      op_and  = 4'd1,
      op_or   = 4'd2,
      op_eor  = 4'd3,
      op_add  = 4'd4,
      op_inc  = 4'd5,
      op_dec  = 4'd6,
      op_cmp  = 4'd7,
      op_asl  = 4'd8,
      op_lsr  = 4'd9,
      op_ror  = 4'd10,
      op_rol  = 4'd11
   } alu_op_t;                                   // codes 12..15 are illegal

   typedef enum logic [1:0] {
      sel_a = 2'd0,
      sel_x = 2'd1,
      sel_y = 2'd2
   } reg_sel_t;                                  // code 3 is illegal

   typedef logic [`AXIL_AW-1:0] reg_ofs_t;       // byte offset into the register map

   function automatic logic is_legal_op(alu_op_t op);
      return op <= op_rol;
   endfunction

   function automatic logic is_legal_sel(reg_sel_t sel);
      return sel inside {sel_a, sel_x, sel_y};
   endfunction

endpackage

`default_nettype wire

/* src/cpu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module cpu_alu (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    start,
   input  wire alu_pkg::alu_op_t  op,
   input  wire [`ALU_DW-1:0]      in_a,
   input  wire [`ALU_DW-1:0]      in_b,
   input  wire                    set_c,
   input  wire                    clr_c,
   output logic [`ALU_DW-1:0]     result,
   output logic                   wb_en,
   output logic                   flag_c,
   output logic                   flag_z,
   output logic                   flag_v,
   output logic                   flag_n
);

   // what the flag stage does with the registered result
   typedef enum logic [2:0] {
      post_idle,
      post_zn,
      post_add,
      post_cmp,
      post_shift
   } post_t;

   logic [`ALU_DW:0]   res_q;
   logic [`ALU_DW:0]   sum;
   logic [`ALU_DW:0]   diff;
   logic               next_c;
   logic               next_v;
   post_t              post_op;

   assign sum    = {1'b0, in_a} + {1'b0, in_b} + {{`ALU_DW{1'b0}}, flag_c};
   assign diff   = {1'b0, in_a} - {1'b0, in_b};   // bit 8 is the borrow
   assign result = res_q[`ALU_DW-1:0];

   always_ff @(posedge clk)
   begin
      if (start)
      begin
         next_v <= (in_a[`ALU_DW-1] == in_b[`ALU_DW-1]) &&
                   (sum[`ALU_DW-1] != in_a[`ALU_DW-1]);
         next_c <= 1'b0;
         case (op)
            alu_pkg::op_pass: res_q <= {1'b0, in_a};
            alu_pkg::op_and:  res_q <= {1'b0, in_a & in_b};
            alu_pkg::op_or:   res_q <= {1'b0, in_a | in_b};
            alu_pkg::op_eor:  res_q <= {1'b0, in_a ^ in_b};
            alu_pkg::op_add:  res_q <= sum;
            alu_pkg::op_inc:  res_q <= {1'b0, in_a + 1'b1};
            alu_pkg::op_dec:  res_q <= {1'b0, in_a - 1'b1};
            alu_pkg::op_cmp:  res_q <= diff;
            alu_pkg::op_asl:
            begin
               res_q  <= {in_a, 1'b0};
               next_c <= in_a[`ALU_DW-1];
            end
            alu_pkg::op_lsr:
            begin
               res_q  <= {2'b00, in_a[`ALU_DW-1:1]};
               next_c <= in_a[0];
            end
            alu_pkg::op_rol:
            begin
               res_q  <= {in_a, flag_c};            // carry shifts in at bit 0
               next_c <= in_a[`ALU_DW-1];
            end
            alu_pkg::op_ror:
            begin
               res_q  <= {1'b0, flag_c, in_a[`ALU_DW-1:1]};
               next_c <= in_a[0];
            end
            default:          res_q <= '0;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         post_op <= post_idle;
         wb_en   <= 1'b0;
      end
      else
      begin
         wb_en <= start && (op != alu_pkg::op_cmp);   // compare only sets flags
         if (!start)
            post_op <= post_idle;
         else
            case (op)
               alu_pkg::op_add: post_op <= post_add;
               alu_pkg::op_cmp: post_op <= post_cmp;
               alu_pkg::op_asl,
               alu_pkg::op_lsr,
               alu_pkg::op_rol,
               alu_pkg::op_ror: post_op <= post_shift;
               default:         post_op <= post_zn;
            endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         flag_c <= 1'b0;
         flag_z <= 1'b0;
         flag_v <= 1'b0;
         flag_n <= 1'b0;
      end
      else
      begin
         if (post_op != post_idle)
         begin
            flag_z <= (res_q[`ALU_DW-1:0] == '0);
            flag_n <= res_q[`ALU_DW-1];
         end
         if (post_op == post_add)
            flag_v <= next_v;
         if (set_c)
            flag_c <= 1'b1;
         else if (clr_c)
            flag_c <= 1'b0;
         else
            case (post_op)
               post_add:   flag_c <= res_q[`ALU_DW];
               post_cmp:   flag_c <= !res_q[`ALU_DW];   // no borrow means C set
               post_shift: flag_c <= next_c;
               default:    ;
            endcase
      end
   end

   a_start_legal: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> alu_pkg::is_legal_op(op));

   // a carry write must not race the operand fetch or the flag stage
   a_no_carry_ctl: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> !(set_c || clr_c) [*2]);

endmodule

`default_nettype wire

/* src/alu_regs.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_regs (
   input  wire                    clk,
   input  wire                    rst_n,
   input  wire                    host_we,
   input  wire alu_pkg::reg_sel_t host_sel,
   input  wire [`ALU_DW-1:0]      host_data,
   input  wire                    wb_en,
   input  wire alu_pkg::reg_sel_t wb_sel,
   input  wire [`ALU_DW-1:0]      wb_data,
   input  wire alu_pkg::reg_sel_t rd_sel_a,
   input  wire alu_pkg::reg_sel_t rd_sel_b,
   output logic [`ALU_DW-1:0]     rd_a,
   output logic [`ALU_DW-1:0]     rd_b
);

   logic [`ALU_DW-1:0] reg_a;
   logic [`ALU_DW-1:0] reg_x;
   logic [`ALU_DW-1:0] reg_y;
   logic               we;
   alu_pkg::reg_sel_t  wsel;
   logic [`ALU_DW-1:0] wdat;

   function automatic logic [`ALU_DW-1:0] pick(alu_pkg::reg_sel_t sel);
      case (sel)
         alu_pkg::sel_x: return reg_x;
         alu_pkg::sel_y: return reg_y;
         default:        return reg_a;
      endcase
   endfunction

   // write-back has priority over the host
   assign we   = wb_en || host_we;
   assign wsel = wb_en ? wb_sel : host_sel;
   assign wdat = wb_en ? wb_data : host_data;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         reg_a <= '0;
         reg_x <= '0;
         reg_y <= '0;
      end
      else if (we)
         case (wsel)
            alu_pkg::sel_a: reg_a <= wdat;
            alu_pkg::sel_x: reg_x <= wdat;
            alu_pkg::sel_y: reg_y <= wdat;
            default:        ;
         endcase
   end

   assign rd_a = pick(rd_sel_a);
   assign rd_b = pick(rd_sel_b);

   // controller holds host writes off while a command is in flight
   a_one_writer: assert property (@(posedge clk) disable iff (!rst_n)
      !(host_we && wb_en));

endmodule

`default_nettype wire

/* src/alu_axil_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_axil_ctrl (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire alu_pkg::reg_ofs_t   awaddr,
   input  wire                      awvalid,
   output logic                     awready,
   input  wire [`AXIL_DW-1:0]       wdata,
   input  wire [`AXIL_DW/8-1:0]     wstrb,
   input  wire                      wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  wire                      bready,
   input  wire alu_pkg::reg_ofs_t   araddr,
   input  wire                      arvalid,
   output logic                     arready,
   output logic [`AXIL_DW-1:0]      rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  wire                      rready,
   output logic                     host_we,
   output alu_pkg::reg_sel_t        host_sel,
   output logic [`ALU_DW-1:0]       host_data,
   output logic                     start,
   output alu_pkg::alu_op_t         op,
   output alu_pkg::reg_sel_t        cmd_sel_a,
   output alu_pkg::reg_sel_t        cmd_sel_b,
   output alu_pkg::reg_sel_t        wb_sel,
   output logic                     set_c,
   output logic                     clr_c,
   input  wire                      flag_c,
   input  wire                      flag_z,
   input  wire                      flag_v,
   input  wire                      flag_n,
   input  wire [`ALU_DW-1:0]        rd_a,
   input  wire [`ALU_DW-1:0]        rd_b
);

   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   logic                   aw_held;
   logic                   w_held;
   alu_pkg::reg_ofs_t      aw_addr_q;
   logic [`AXIL_DW-1:0]    w_data_q;
   logic [`AXIL_DW/8-1:0]  w_strb_q;
   alu_pkg::reg_ofs_t      wr_addr;
   logic [`AXIL_DW-1:0]    wr_data;
   logic [`AXIL_DW/8-1:0]  wr_strb;
   logic                   wr_go;
   logic                   wr_is_reg;
   logic                   cmd_ok;
   logic                   wr_err;
   logic                   do_host;
   logic                   do_cmd;
   logic                   do_flag;
   alu_pkg::reg_sel_t      wr_sel;
   alu_pkg::reg_sel_t      sel_a_q;
   alu_pkg::reg_sel_t      sel_b_q;
   logic [1:0]             busy_cnt;
   logic                   busy;
   logic                   ar_is_reg;
   logic [`AXIL_DW-1:0]    status_word;

   assign busy = (busy_cnt != 2'd0);

   // one write at a time, nothing accepted while a command runs
   assign awready = !aw_held && !bvalid && !busy;
   assign wready  = !w_held && !bvalid && !busy;

   assign wr_addr = aw_held ? aw_addr_q : awaddr;
   assign wr_data = w_held ? w_data_q : wdata;
   assign wr_strb = w_held ? w_strb_q : wstrb;
   assign wr_go   = (aw_held || (awvalid && awready)) && (w_held || (wvalid && wready));

   assign wr_is_reg = (wr_addr == `REG_A_OFS) || (wr_addr == `REG_X_OFS) ||
                      (wr_addr == `REG_Y_OFS);
   assign cmd_ok = alu_pkg::is_legal_op(alu_pkg::alu_op_t'(wr_data[3:0])) &&
                   alu_pkg::is_legal_sel(alu_pkg::reg_sel_t'(wr_data[5:4])) &&
                   alu_pkg::is_legal_sel(alu_pkg::reg_sel_t'(wr_data[7:6])) &&
                   alu_pkg::is_legal_sel(alu_pkg::reg_sel_t'(wr_data[9:8]));
   assign wr_err = !(wr_is_reg || (wr_addr == `FLAGCTL_OFS) ||
                     ((wr_addr == `CMD_OFS) && cmd_ok));

   // lanes not strobed make the write a no-op, still OKAY
   assign do_host = wr_go && wr_is_reg && wr_strb[0];
   assign do_cmd  = wr_go && (wr_addr == `CMD_OFS) && cmd_ok && (wr_strb[1:0] == 2'b11);
   assign do_flag = wr_go && (wr_addr == `FLAGCTL_OFS) && wr_strb[0];

   always_comb
   begin
      case (wr_addr)
         `REG_X_OFS: wr_sel = alu_pkg::sel_x;
         `REG_Y_OFS: wr_sel = alu_pkg::sel_y;
         default:    wr_sel = alu_pkg::sel_a;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         aw_held  <= 1'b0;
         w_held   <= 1'b0;
         bvalid   <= 1'b0;
         host_we  <= 1'b0;
         start    <= 1'b0;
         set_c    <= 1'b0;
         clr_c    <= 1'b0;
         busy_cnt <= 2'd0;
      end
      else
      begin
         host_we <= do_host;
         start   <= do_cmd;
         set_c   <= do_flag && wr_data[0];
         clr_c   <= do_flag && wr_data[1] && !wr_data[0];   // set wins
         if (do_cmd)
            busy_cnt <= 2'd2;                  // busy through start and write-back
         else if (busy)
            busy_cnt <= busy_cnt - 2'd1;
         if (wr_go)
         begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
            bvalid  <= 1'b1;
         end
         else
         begin
            if (awvalid && awready)
               aw_held <= 1'b1;
            if (wvalid && wready)
               w_held <= 1'b1;
            if (bvalid && bready)
               bvalid <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (awvalid && awready)
         aw_addr_q <= awaddr;
      if (wvalid && wready)
      begin
         w_data_q <= wdata;
         w_strb_q <= wstrb;
      end
      if (wr_go)
         bresp <= wr_err ? resp_slverr : resp_okay;
      if (do_host)
      begin
         host_sel  <= wr_sel;
         host_data <= wr_data[`ALU_DW-1:0];
      end
      if (do_cmd)
      begin
         op      <= alu_pkg::alu_op_t'(wr_data[3:0]);
         sel_a_q <= alu_pkg::reg_sel_t'(wr_data[5:4]);
         sel_b_q <= alu_pkg::reg_sel_t'(wr_data[7:6]);
         wb_sel  <= alu_pkg::reg_sel_t'(wr_data[9:8]);
      end
   end

   // idle read path borrows the ports, A and X on port a, Y on port b
   assign cmd_sel_a = busy ? sel_a_q :
                      ((araddr == `REG_X_OFS) ? alu_pkg::sel_x : alu_pkg::sel_a);
   assign cmd_sel_b = busy ? sel_b_q : alu_pkg::sel_y;

   assign ar_is_reg = (araddr == `REG_A_OFS) || (araddr == `REG_X_OFS) ||
                      (araddr == `REG_Y_OFS);
   assign arready   = !rvalid && !(busy && ar_is_reg);

   assign status_word = {{(`AXIL_DW-9){1'b0}}, busy, 4'b0000, flag_n, flag_v, flag_z, flag_c};

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         rvalid <= 1'b0;
      else if (arvalid && arready)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (arvalid && arready)
      begin
         rresp <= resp_okay;
         rdata <= '0;
         case (araddr)
            `REG_A_OFS,
            `REG_X_OFS:   rdata <= {{(`AXIL_DW-`ALU_DW){1'b0}}, rd_a};
            `REG_Y_OFS:   rdata <= {{(`AXIL_DW-`ALU_DW){1'b0}}, rd_b};
            `STATUS_OFS:  rdata <= status_word;
            `CMD_OFS,
            `FLAGCTL_OFS: ;                      // write-only, reads as zero
            default:      rresp <= resp_slverr;
         endcase
      end
   end

   a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      bvalid && !bready |=> bvalid && $stable(bresp));

   a_rvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
      rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp));

   a_start_idle: assert property (@(posedge clk) disable iff (!rst_n)
      start |-> !$past(busy));

endmodule

`default_nettype wire

/* src/alu_core_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_core_top (
   input  wire                      clk,
   input  wire                      rst_n,
   input  wire alu_pkg::reg_ofs_t   awaddr,
   input  wire                      awvalid,
   output logic                     awready,
   input  wire [`AXIL_DW-1:0]       wdata,
   input  wire [`AXIL_DW/8-1:0]     wstrb,
   input  wire                      wvalid,
   output logic                     wready,
   output logic [1:0]               bresp,
   output logic                     bvalid,
   input  wire                      bready,
   input  wire alu_pkg::reg_ofs_t   araddr,
   input  wire                      arvalid,
   output logic                     arready,
   output logic [`AXIL_DW-1:0]      rdata,
   output logic [1:0]               rresp,
   output logic                     rvalid,
   input  wire                      rready
);

   logic                host_we;
   alu_pkg::reg_sel_t   host_sel;
   logic [`ALU_DW-1:0]  host_data;
   logic                start;
   alu_pkg::alu_op_t    op;
   alu_pkg::reg_sel_t   cmd_sel_a;
   alu_pkg::reg_sel_t   cmd_sel_b;
   alu_pkg::reg_sel_t   wb_sel;
   logic                set_c;
   logic                clr_c;
   logic                flag_c;
   logic                flag_z;
   logic                flag_v;
   logic                flag_n;
   logic [`ALU_DW-1:0]  rd_a;
   logic [`ALU_DW-1:0]  rd_b;
   logic [`ALU_DW-1:0]  result;
   logic                wb_en;

   alu_axil_ctrl u_ctrl (
      .clk       (clk),
      .rst_n     (rst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .host_we   (host_we),
      .host_sel  (host_sel),
      .host_data (host_data),
      .start     (start),
      .op        (op),
      .cmd_sel_a (cmd_sel_a),
      .cmd_sel_b (cmd_sel_b),
      .wb_sel    (wb_sel),
      .set_c     (set_c),
      .clr_c     (clr_c),
      .flag_c    (flag_c),
      .flag_z    (flag_z),
      .flag_v    (flag_v),
      .flag_n    (flag_n),
      .rd_a      (rd_a),
      .rd_b      (rd_b)
   );

   alu_regs u_regs (
      .clk       (clk),
      .rst_n     (rst_n),
      .host_we   (host_we),
      .host_sel  (host_sel),
      .host_data (host_data),
      .wb_en     (wb_en),
      .wb_sel    (wb_sel),
      .wb_data   (result),
      .rd_sel_a  (cmd_sel_a),
      .rd_sel_b  (cmd_sel_b),
      .rd_a      (rd_a),
      .rd_b      (rd_b)
   );

   cpu_alu u_alu (
      .clk       (clk),
      .rst_n     (rst_n),
      .start     (start),
      .op        (op),
      .in_a      (rd_a),
      .in_b      (rd_b),
      .set_c     (set_c),
      .clr_c     (clr_c),
      .result    (result),
      .wb_en     (wb_en),
      .flag_c    (flag_c),
      .flag_z    (flag_z),
      .flag_v    (flag_v),
      .flag_n    (flag_n)
   );

endmodule

`default_nettype wire

/* dv/alu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "alu_macros.svh"

module alu_tb;

   localparam int wait_limit = 40;               // cycles per handshake wait

   localparam logic [3:0] logic_ops [0:3] = '{alu_pkg::op_pass, alu_pkg::op_and,
                                              alu_pkg::op_or, alu_pkg::op_eor};
   localparam logic [3:0] shift_ops [0:5] = '{alu_pkg::op_inc, alu_pkg::op_dec,
                                              alu_pkg::op_asl, alu_pkg::op_lsr,
                                              alu_pkg::op_ror, alu_pkg::op_rol};
   localparam logic [7:0] add_a [0:4] = '{8'h7f, 8'hff, 8'h80, 8'h7f, 8'hff};
   localparam logic [7:0] add_b [0:4] = '{8'h01, 8'h01, 8'h80, 8'h00, 8'h00};
   localparam logic       add_c [0:4] = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1};

   logic        clk = 1'b0;
   logic        rst_n;
   logic [7:0]  awaddr;
   logic        awvalid;
   logic        awready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        wvalid;
   logic        wready;
   logic [1:0]  bresp;
   logic        bvalid;
   logic        bready;
   logic [7:0]  araddr;
   logic        arvalid;
   logic        arready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic        rvalid;
   logic        rready;

   logic [7:0]  m_regs [0:2];                    // model of A, X, Y
   logic        m_c = 1'b0;
   logic        m_z = 1'b0;
   logic        m_v = 1'b0;
   logic        m_n = 1'b0;
   int          cyc = 0;
   int          cmd_cyc = -100;
   int          checks = 0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          errors_at_start = 0;

   alu_core_top uut (
      .clk     (clk),
      .rst_n   (rst_n),
      .awaddr  (awaddr),
      .awvalid (awvalid),
      .awready (awready),
      .wdata   (wdata),
      .wstrb   (wstrb),
      .wvalid  (wvalid),
      .wready  (wready),
      .bresp   (bresp),
      .bvalid  (bvalid),
      .bready  (bready),
      .araddr  (araddr),
      .arvalid (arvalid),
      .arready (arready),
      .rdata   (rdata),
      .rresp   (rresp),
      .rvalid  (rvalid),
      .rready  (rready)
   );

   always #5 clk = ~clk;

   function automatic logic cmd_legal(input logic [31:0] d);
      return (d[3:0] <= 4'd11) && (d[5:4] != 2'd3) && (d[7:6] != 2'd3) && (d[9:8] != 2'd3);
   endfunction

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (awvalid && awready && wvalid && wready && awaddr == `CMD_OFS && cmd_legal(wdata))
         cmd_cyc <= cyc;                         // cycle T of the last legal command
   end

   // busy lasts through T+2, so nothing is accepted before T+3
   a_held_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && awready |-> (cyc - cmd_cyc) >= 3)
      else
      begin
         $display("ERROR %0t: write accepted while a command was in flight", $time);
         errors++;
      end

   a_bresp_next: assert property (@(posedge clk) disable iff (!rst_n)
      awvalid && awready && wvalid && wready |=> bvalid)
      else
      begin
         $display("ERROR %0t: bvalid not raised after write transfer", $time);
         errors++;
      end

   a_rresp_next: assert property (@(posedge clk) disable iff (!rst_n)
      arvalid && arready |=> rvalid)
      else
      begin
         $display("ERROR %0t: rvalid not raised after read transfer", $time);
         errors++;
      end

   task automatic abort_run(input string why);
      $display("%s at %0t, stopping", why, $time);
      $display("Some tests failed");
      $finish;
   endtask

   task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      assert (got === exp)
      else
      begin
         $display("ERROR %0t: %s is %h, expected %h", $time, what, got, exp);
         errors++;
      end
   endtask

   // called right after a rising edge, returns right after the transfer edge
   task automatic write_addr_data(input logic [7:0] addr, input logic [31:0] data);
      logic aw_hit;
      logic w_hit;
      logic aw_done;
      logic w_done;
      int   n;
      awaddr  <= addr;
      awvalid <= 1'b1;
      wdata   <= data;
      wstrb   <= 4'hf;
      wvalid  <= 1'b1;
      aw_done = 1'b0;
      w_done  = 1'b0;
      n       = 0;
      while (!(aw_done && w_done))
      begin
         @(negedge clk);
         aw_hit = awvalid && awready;
         w_hit  = wvalid && wready;
         @(posedge clk);
         if (aw_hit)
         begin
            aw_done = 1'b1;
            awvalid <= 1'b0;
         end
         if (w_hit)
         begin
            w_done = 1'b1;
            wvalid <= 1'b0;
         end
         n++;
         if (n > wait_limit)
            abort_run("timed out waiting for awready and wready");
      end
   endtask

   task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
      logic got;
      int   n;
      write_addr_data(addr, data);
      got = 1'b0;
      n   = 0;
      while (!got)
      begin
         @(negedge clk);
         if (bvalid)
         begin
            got  = 1'b1;
            resp = bresp;
         end
         @(posedge clk);                         // bready is always high
         n++;
         if (n > wait_limit)
            abort_run("timed out waiting for bvalid");
      end
   endtask

   task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
      logic hit;
      int   n;
      araddr  <= addr;
      arvalid <= 1'b1;
      hit = 1'b0;
      n   = 0;
      while (!hit)
      begin
         @(negedge clk);
         hit = arready;
         @(posedge clk);
         if (hit)
            arvalid <= 1'b0;
         n++;
         if (n > wait_limit)
            abort_run("timed out waiting for arready");
      end
      hit = 1'b0;
      n   = 0;
      while (!hit)
      begin
         @(negedge clk);
         if (rvalid)
         begin
            hit  = 1'b1;
            data = rdata;
            resp = rresp;
         end
         @(posedge clk);
         n++;
         if (n > wait_limit)
            abort_run("timed out waiting for rvalid");
      end
   endtask

   task automatic apply_model(input logic [3:0] op, input int sa, input int sb, input int dst);
      logic [7:0] a;
      logic [7:0] b;
      int         total;
      int         signed_total;
      logic [7:0] res;
      a   = m_regs[sa];
      b   = m_regs[sb];
      res = 8'h00;
      case (op)
         alu_pkg::op_pass: res = a;
         alu_pkg::op_and:  res = a & b;
         alu_pkg::op_or:   res = a | b;
         alu_pkg::op_eor:  res = a ^ b;
         alu_pkg::op_add:
         begin
            total        = int'(a) + int'(b) + int'(m_c);
            signed_total = int'($signed(a)) + int'($signed(b)) + int'(m_c);
            res          = total[7:0];
            m_v          = (signed_total > 127) || (signed_total < -128);   // out of int8 range
            m_c          = (total > 255);
         end
         alu_pkg::op_inc:  res = a + 8'd1;
         alu_pkg::op_dec:  res = a - 8'd1;
         alu_pkg::op_cmp:
         begin
            res = a - b;
            m_c = (a >= b);
         end
         alu_pkg::op_asl:
         begin
            res = {a[6:0], 1'b0};
            m_c = a[7];
         end
         alu_pkg::op_lsr:
         begin
            res = {1'b0, a[7:1]};
            m_c = a[0];
         end
         alu_pkg::op_ror:
         begin
            res = {m_c, a[7:1]};
            m_c = a[0];
         end
         alu_pkg::op_rol:
         begin
            res = {a[6:0], m_c};
            m_c = a[7];
         end
         default: ;
      endcase
      m_z = (res == 8'h00);
      m_n = res[7];
      if (op != alu_pkg::op_cmp)
         m_regs[dst] = res;
   endtask

   task automatic wait_idle();
      logic [31:0] data;
      logic [1:0]  resp;
      int          n;
      n    = 0;
      data = 32'h100;
      while (data[8])
      begin
         axil_read(`STATUS_OFS, data, resp);
         n++;
         if (n > wait_limit)
            abort_run("busy never cleared");
      end
   endtask

   task automatic set_reg(input int idx, input logic [7:0] val);
      logic [1:0] resp;
      axil_write(8'(idx * 4), {24'h0, val}, resp);
      check_eq("register write response", {30'h0, resp}, 32'h0);
      m_regs[idx] = val;
   endtask

   task automatic load_random_regs();
      for (int i = 0; i < 3; i++)
         set_reg(i, 8'($urandom_range(255, 0)));
   endtask

   task automatic set_carry(input logic [1:0] ctl);
      logic [1:0] resp;
      axil_write(`FLAGCTL_OFS, {30'h0, ctl}, resp);
      check_eq("flag control response", {30'h0, resp}, 32'h0);
      if (ctl[0])
         m_c = 1'b1;
      else if (ctl[1])
         m_c = 1'b0;
   endtask

   task automatic run_cmd(input logic [3:0] op, input int sa, input int sb, input int dst);
      logic [1:0] resp;
      axil_write(`CMD_OFS, {22'h0, 2'(dst), 2'(sb), 2'(sa), op}, resp);
      check_eq("command response", {30'h0, resp}, 32'h0);
      wait_idle();
      apply_model(op, sa, sb, dst);
   endtask

   task automatic check_state();
      logic [31:0] data;
      logic [1:0]  resp;
      for (int i = 0; i < 3; i++)
      begin
         axil_read(8'(i * 4), data, resp);
         check_eq($sformatf("register %0d", i), data, {24'h0, m_regs[i]});
         check_eq("register read response", {30'h0, resp}, 32'h0);
      end
      axil_read(`STATUS_OFS, data, resp);
      check_eq("status", data, {28'h0, m_n, m_v, m_z, m_c});
      check_eq("status read response", {30'h0, resp}, 32'h0);
   endtask

   task automatic begin_test();
      errors_at_start = errors;
   endtask

   task automatic end_test(input int num, input string name);
      tests_run++;
      if (errors != errors_at_start)
         tests_failed++;
      $display("test %0d %s: %s", num, name, (errors == errors_at_start) ? "ok" : "FAILED");
   endtask

   task automatic reg_round_trip();
      begin_test();
      for (int i = 0; i < 3; i++)
         m_regs[i] = 8'h00;
      check_state();                             // flags and registers zero after reset
      for (int k = 0; k < 4; k++)
      begin
         load_random_regs();
         check_state();
      end
      end_test(1, "register access");
   endtask

   task automatic logic_op_sweep();
      begin_test();
      for (int k = 0; k < 10; k++)
      begin
         load_random_regs();
         run_cmd(logic_ops[$urandom_range(3, 0)], $urandom_range(2, 0),
                 $urandom_range(2, 0), $urandom_range(2, 0));
         check_state();
      end
      end_test(2, "logic and pass ops");
   endtask

   task automatic add_carry_cases();
      begin_test();
      for (int k = 0; k < 5; k++)
      begin
         set_reg(0, add_a[k]);
         set_reg(1, add_b[k]);
         set_carry(add_c[k] ? 2'b01 : 2'b10);
         run_cmd(alu_pkg::op_add, 0, 1, 2);
         check_state();
      end
      set_carry(2'b10);
      set_carry(2'b11);                          // set wins over clear
      check_state();
      for (int k = 0; k < 8; k++)
      begin
         load_random_regs();
         set_carry(($urandom_range(1, 0) == 1) ? 2'b01 : 2'b10);
         run_cmd(alu_pkg::op_add, $urandom_range(2, 0), $urandom_range(2, 0),
                 $urandom_range(2, 0));
         check_state();
      end
      end_test(3, "add with carry");
   endtask

   task automatic shift_and_step();
      begin_test();
      for (int k = 0; k < 18; k++)
      begin
         if (k % 3 == 0)
            load_random_regs();
         set_carry(($urandom_range(1, 0) == 1) ? 2'b01 : 2'b10);
         run_cmd(shift_ops[k % 6], $urandom_range(2, 0), 0, $urandom_range(2, 0));
         check_state();
      end
      end_test(4, "shifts, rotates, inc, dec");
   endtask

   task automatic compare_sweep();
      begin_test();
      for (int k = 0; k < 8; k++)
      begin
         load_random_regs();
         if (k == 0)
            set_reg(1, m_regs[0]);               // equal operands
         run_cmd(alu_pkg::op_cmp, (k == 0) ? 0 : $urandom_range(2, 0),
                 (k == 0) ? 1 : $urandom_range(2, 0), $urandom_range(2, 0));
         check_state();
      end
      end_test(5, "compare");
   endtask

   task automatic error_and_stall();
      logic [31:0] data;
      logic [1:0]  resp;
      logic [7:0]  xval;
      begin_test();
      load_random_regs();
      axil_write(`CMD_OFS, {22'h0, 6'b00_01_00, 4'(12 + $urandom_range(3, 0))}, resp);
      check_eq("illegal op response", {30'h0, resp}, 32'h2);
      axil_write(`CMD_OFS, {22'h0, 2'd0, 2'd1, 2'd3, alu_pkg::op_and}, resp);
      check_eq("illegal source response", {30'h0, resp}, 32'h2);
      axil_write(`CMD_OFS, {22'h0, 2'd3, 2'd1, 2'd0, alu_pkg::op_pass}, resp);
      check_eq("illegal destination response", {30'h0, resp}, 32'h2);
      check_state();
      axil_write(8'h18, 32'h5a, resp);
      check_eq("unmapped write response", {30'h0, resp}, 32'h2);
      axil_read(8'h20, data, resp);
      check_eq("unmapped read response", {30'h0, resp}, 32'h2);
      check_eq("unmapped read data", data, 32'h0);
      check_state();
      // register write straight behind a command
      load_random_regs();
      write_addr_data(`CMD_OFS, {22'h0, 2'd2, 2'd1, 2'd0, alu_pkg::op_add});
      xval = 8'($urandom_range(255, 0));
      axil_write(`REG_X_OFS, {24'h0, xval}, resp);
      check_eq("held write response", {30'h0, resp}, 32'h0);
      apply_model(alu_pkg::op_add, 0, 1, 2);
      m_regs[1] = xval;
      check_state();
      end_test(6, "errors and back-pressure");
   endtask

   initial
   begin
      void'($urandom(32'h4edb863f));
      rst_n   = 1'b0;
      awaddr  = 8'h00;
      awvalid = 1'b0;
      wdata   = 32'h0;
      wstrb   = 4'h0;
      wvalid  = 1'b0;
      bready  = 1'b1;
      araddr  = 8'h00;
      arvalid = 1'b0;
      rready  = 1'b1;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      reg_round_trip();
      logic_op_sweep();
      add_carry_cases();
      shift_and_step();
      compare_sweep();
      error_and_stall();
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, checks, errors);
      if (errors == 0 && tests_failed == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+src
src/alu_pkg.sv
src/cpu_alu.sv
src/alu_regs.sv
src/alu_axil_ctrl.sv
src/alu_core_top.sv
dv/alu_tb.sv

/* Makefile */
SIM      := verilator
VFLAGS   := --binary --timing --assert -Wno-fatal
TOP      := alu_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)
LOG      := sim.log
PASS_MSG := All tests passed

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard src/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
